// ==== mont_pkg.sv ====
package mont_pkg;

  // operand width when the top level keeps its default
  parameter int default_width = 1024;

  // radix 4 so two bits of a are consumed per iteration
  parameter int digit_bits = 2;

  // acc stays below 8m before the shift and needs three bits above n
  parameter int acc_guard_bits = 3;

  // multiple of an operand that a unit returns to the core
  typedef enum logic [1:0] {
    mult_zero  = 2'd0,
    mult_one   = 2'd1,
    mult_two   = 2'd2,
    mult_three = 2'd3
  } multiple_sel_e;

  // core control states
  typedef enum logic [2:0] {
    idle        = 3'd0, // waiting for start
    prep        = 3'd1, // multiples being formed
    add_digit   = 3'd2, // acc += digit * b
    add_m_shift = 3'd3, // acc = (acc + q * m) / 4
    reduce      = 3'd4  // final conditional subtract
  } mont_state_e;

endpackage

// ==== mont_multiples_if.sv ====
`timescale 1ns/1ps

// one operand's 1x/2x/3x multiples as seen by the core
interface mont_multiples_if #(
  parameter int width = mont_pkg::default_width
);

  mont_pkg::multiple_sel_e sel;      // which multiple the core wants
  logic [width+1:0]        multiple; // selected multiple, comb from sel
  logic [1:0]              low_bits; // operand mod 4
  logic                    ready;    // 3x valid for the current load

  modport unit (
    input  sel,
    output multiple,
    output low_bits,
    output ready
  );

  modport core (
    output sel,
    input  multiple,
    input  low_bits,
    input  ready
  );

endinterface

// ==== operand_multiples.sv ====
`timescale 1ns/1ps

// holds 1x, 2x and 3x of one operand and serves the one selected
module operand_multiples #(
  parameter int width = mont_pkg::default_width
) (
  input  logic             clk,
  input  logic             resetn,
  input  logic             load,
  input  logic [width-1:0] operand,
  mont_multiples_if.unit   mult
);

  logic [width-1:0] one_q;
  logic [width:0]   two_q;
  logic [width+1:0] three_q;

  logic triple_pending; // 1x/2x fresh, 3x still old
  logic ready_q;

  // operand and its double on load, triple one cycle later
  always_ff @(posedge clk) begin
    if (load) begin
      one_q <= operand;
      two_q <= {operand, 1'b0}; // shift instead of an add
    end
    if (triple_pending) begin
      three_q <= {2'b00, one_q} + {1'b0, two_q};
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      triple_pending <= 1'b0;
      ready_q        <= 1'b0;
    end else begin
      triple_pending <= load;
      if (load) begin
        ready_q <= 1'b0;     // drop straight away on a new operand
      end else if (triple_pending) begin
        ready_q <= 1'b1;
      end
    end
  end

  always_comb begin
    unique case (mult.sel)
      mont_pkg::mult_one:   mult.multiple = {2'b00, one_q};
      mont_pkg::mult_two:   mult.multiple = {1'b0, two_q};
      mont_pkg::mult_three: mult.multiple = three_q;
      default:              mult.multiple = '0;
    endcase
  end

  // only the m side uses these, for the quotient digit
  assign mult.low_bits = one_q[1:0];
  assign mult.ready    = ready_q;

endmodule

// ==== mont_digit_core.sv ====
`timescale 1ns/1ps

// radix-4 montgomery loop
// acc += digit(a) * b, then acc = (acc + q * m) / 4, n/2 times
module mont_digit_core #(
  parameter int width = mont_pkg::default_width
) (
  input  logic             clk,
  input  logic             resetn,
  input  logic             start,
  input  logic [width-1:0] in_a,
  mont_multiples_if.core   b_mult,
  mont_multiples_if.core   m_mult,
  output logic             load,
  output logic [width-1:0] result,
  output logic             done,
  output logic             busy
);

  localparam int acc_width  = width + mont_pkg::acc_guard_bits;
  localparam int iterations = width / mont_pkg::digit_bits;
  localparam int cnt_width  = (iterations > 1) ? $clog2(iterations) : 1;

  mont_pkg::mont_state_e state;
  mont_pkg::mont_state_e state_next;

  logic [width-1:0]     a_q;       // shifts down one digit per iteration
  logic [cnt_width-1:0] iter_cnt;
  logic [acc_width-1:0] acc;
  logic [width-1:0]     result_q;

  logic                 accept;    // start taken this cycle
  logic                 last_iter;
  logic [width+1:0]     addend;
  logic [acc_width-1:0] acc_sum;
  logic [1:0]           neg_acc;   // -acc mod 4
  logic [1:0]           q_digit;
  logic [acc_width-1:0] m_ext;
  logic [acc_width-1:0] acc_minus_m;
  logic                 acc_ge_m;
  logic [width-1:0]     final_value;

  assign busy   = (state == mont_pkg::prep) ||
                  (state == mont_pkg::add_digit) ||
                  (state == mont_pkg::add_m_shift);
  assign accept = start && !busy;
  assign load   = accept;   // both units capture their operand now
  assign done   = (state == mont_pkg::reduce);

  assign last_iter = (iter_cnt == cnt_width'(iterations - 1));

  // q = -acc * m^-1 mod 4, and m^-1 == m mod 4 for odd m
  assign neg_acc = 2'd0 - acc[1:0];
  assign q_digit = neg_acc * m_mult.low_bits;

  // multiple selection for both units
  always_comb begin
    b_mult.sel = mont_pkg::mult_zero;
    m_mult.sel = mont_pkg::mult_zero;
    unique case (state)
      mont_pkg::add_digit: begin
        b_mult.sel = mont_pkg::multiple_sel_e'(a_q[mont_pkg::digit_bits-1:0]);
      end
      mont_pkg::add_m_shift: begin
        m_mult.sel = mont_pkg::multiple_sel_e'(q_digit);
      end
      mont_pkg::reduce: begin
        m_mult.sel = mont_pkg::mult_one; // plain m for the subtraction
      end
      default: begin
      end
    endcase
  end

  // one adder shared by both half-iterations
  assign addend  = (state == mont_pkg::add_m_shift) ? m_mult.multiple : b_mult.multiple;
  assign acc_sum = acc + acc_width'(addend);

  // acc < 2m here, one subtraction is enough
  assign m_ext       = acc_width'(m_mult.multiple);
  assign acc_ge_m    = (acc >= m_ext);
  assign acc_minus_m = acc - m_ext;
  assign final_value = acc_ge_m ? acc_minus_m[width-1:0] : acc[width-1:0];

  // visible in the done cycle, held afterwards
  assign result = done ? final_value : result_q;

  always_comb begin
    state_next = state;
    unique case (state)
      mont_pkg::idle: begin
        if (accept) begin
          state_next = mont_pkg::prep;
        end
      end
      mont_pkg::prep: begin
        if (b_mult.ready && m_mult.ready) begin
          state_next = mont_pkg::add_digit;
        end
      end
      mont_pkg::add_digit: begin
        state_next = mont_pkg::add_m_shift;
      end
      mont_pkg::add_m_shift: begin
        state_next = last_iter ? mont_pkg::reduce : mont_pkg::add_digit;
      end
      mont_pkg::reduce: begin
        // busy already low, so a start here begins the next run
        state_next = accept ? mont_pkg::prep : mont_pkg::idle;
      end
      default: begin
        state_next = mont_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state    <= mont_pkg::idle;
      iter_cnt <= '0;
      result_q <= '0;
    end else begin
      state <= state_next;
      if (accept) begin
        iter_cnt <= '0;
      end else if (state == mont_pkg::add_m_shift) begin
        iter_cnt <= iter_cnt + 1'b1;
      end
      if (done) begin
        result_q <= final_value;
      end
    end
  end

  // datapath, restarted by accept
  always_ff @(posedge clk) begin
    if (accept) begin
      a_q <= in_a;
      acc <= '0;
    end else if (state == mont_pkg::add_digit) begin
      acc <= acc_sum;
    end else if (state == mont_pkg::add_m_shift) begin
      acc <= acc_sum >> mont_pkg::digit_bits; // low two bits are zero by choice of q
      a_q <= a_q >> mont_pkg::digit_bits;     // next digit into the bottom
    end
  end

endmodule

// ==== montgomery_top.sv ====
`timescale 1ns/1ps

// radix-4 montgomery multiplier, result = a * b * 2^-n mod m
module montgomery_top #(
  parameter int width = mont_pkg::default_width
) (
  input  logic             clk,
  input  logic             resetn,
  input  logic             start,
  input  logic [width-1:0] in_a,
  input  logic [width-1:0] in_b,
  input  logic [width-1:0] in_m,
  output logic [width-1:0] result,
  output logic             done,
  output logic             busy
);

  localparam int iterations = width / mont_pkg::digit_bits;

  logic load; // operand capture strobe from the core

  // the loop consumes whole digits only
  if (iterations * mont_pkg::digit_bits != width) begin : g_width_check
    $error("width must be a multiple of the digit size");
  end

  mont_multiples_if #(.width(width)) bmul ();
  mont_multiples_if #(.width(width)) mmul ();

  operand_multiples #(
    .width(width)
  ) b_multiples (
    .clk     (clk),
    .resetn  (resetn),
    .load    (load),
    .operand (in_b),
    .mult    (bmul)
  );

  operand_multiples #(
    .width(width)
  ) m_multiples (
    .clk     (clk),
    .resetn  (resetn),
    .load    (load),
    .operand (in_m),
    .mult    (mmul)
  );

  mont_digit_core #(
    .width(width)
  ) core (
    .clk    (clk),
    .resetn (resetn),
    .start  (start),
    .in_a   (in_a),
    .b_mult (bmul),
    .m_mult (mmul),
    .load   (load),
    .result (result),
    .done   (done),
    .busy   (busy)
  );

endmodule

// ==== tb_montgomery_assertions.sv ====
`timescale 1ns/1ps

// protocol and arithmetic checks on montgomery_top
module tb_montgomery_assertions #(
  parameter int width = mont_pkg::default_width
) (
  input logic                  clk,
  input logic                  resetn,
  input logic                  start,
  input logic [width-1:0]      in_a,
  input logic [width-1:0]      in_b,
  input logic [width-1:0]      in_m,
  input logic [width-1:0]      result,
  input logic                  done,
  input logic                  busy,
  input mont_pkg::mont_state_e core_state
);

  localparam int done_cycle = width + 3; // done comes n+3 cycles after the accepted start

  int unsigned fail_count = 0; // polled by the testbench

  logic             accept;
  logic             exp_busy;    // busy as the timing rules predict it
  logic             exp_done;    // predicted done pulse
  logic             started;     // at least one start taken since reset
  logic             in_run;
  logic             hold_active; // between done and the next accepted start
  int               run_cnt;     // cycles since the accepted start
  logic [width-1:0] held_a;
  logic [width-1:0] held_b;
  logic [width-1:0] held_m;
  logic [width-1:0] held_result;

  logic [2*width-1:0] m_wide;
  logic [2*width-1:0] ab_mod;
  logic [2*width-1:0] r_mod;

  assign exp_busy = in_run && (run_cnt < done_cycle);
  assign exp_done = in_run && (run_cnt == done_cycle);
  assign accept   = start && !exp_busy;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      started     <= 1'b0;
      in_run      <= 1'b0;
      run_cnt     <= 0;
      hold_active <= 1'b0;
    end else begin
      if (accept) begin
        started <= 1'b1;
        in_run  <= 1'b1;
        run_cnt <= 1;
        held_a  <= in_a;
        held_b  <= in_b;
        held_m  <= in_m;
      end else if (in_run) begin
        if (exp_done) begin
          in_run <= 1'b0;
        end else begin
          run_cnt <= run_cnt + 1;
        end
      end
      if (accept) begin
        hold_active <= 1'b0;
      end else if (exp_done) begin
        hold_active <= 1'b1;
        held_result <= result;
      end
    end
  end

  // double width reference for result * 2^n == a * b mod m
  assign m_wide = {{width{1'b0}}, held_m};
  assign ab_mod = (m_wide == '0) ? '0 :
                  ({{width{1'b0}}, held_a} * {{width{1'b0}}, held_b}) % m_wide;
  assign r_mod  = (m_wide == '0) ? '0 : {result, {width{1'b0}}} % m_wide;

  reset_quiet: assert property (
    @(posedge clk) disable iff (!resetn) !started |-> (!done && !busy && result == '0)
  ) else begin
    fail_count++;
    $error("done, busy or result active before the first start");
  end

  busy_level: assert property (
    @(posedge clk) disable iff (!resetn) busy == exp_busy
  ) else begin
    fail_count++;
    $error("busy is %0b in cycle %0d of the run", busy, run_cnt);
  end

  done_timing: assert property (
    @(posedge clk) disable iff (!resetn) done == exp_done
  ) else begin
    fail_count++;
    $error("done is %0b in cycle %0d of the run", done, run_cnt);
  end

  prep_length: assert property (
    @(posedge clk) disable iff (!resetn)
      (in_run && (run_cnt == 1 || run_cnt == 2)) |-> core_state == mont_pkg::prep
  ) else begin
    fail_count++;
    $error("core not in prep during cycle %0d", run_cnt);
  end

  result_below_m: assert property (
    @(posedge clk) disable iff (!resetn) exp_done |-> result < held_m
  ) else begin
    fail_count++;
    $error("result %0h not below modulus %0h", result, held_m);
  end

  result_congruent: assert property (
    @(posedge clk) disable iff (!resetn) exp_done |-> r_mod == ab_mod
  ) else begin
    fail_count++;
    $error("result %0h is not a*b*2^-n mod m", result);
  end

  result_hold: assert property (
    @(posedge clk) disable iff (!resetn) hold_active |-> result == held_result
  ) else begin
    fail_count++;
    $error("result moved from %0h to %0h after done", held_result, result);
  end

endmodule

bind montgomery_top tb_montgomery_assertions #(
  .width(width)
) checks (
  .clk        (clk),
  .resetn     (resetn),
  .start      (start),
  .in_a       (in_a),
  .in_b       (in_b),
  .in_m       (in_m),
  .result     (result),
  .done       (done),
  .busy       (busy),
  .core_state (core.state)
);

// ==== tb_montgomery.sv ====
`timescale 1ns/1ps

module tb_montgomery;

  localparam int unsigned seed       = 32'hefc28fde;
  localparam int          test_width = 128;
  localparam int          test_count = 12;
  localparam int          period     = 40;
  localparam int          reset_len  = 10;

  // every test fits in width+10 cycles
  localparam longint watchdog_ns =
    longint'(test_count * (test_width + 10) + reset_len) * period;

  logic                  clk;
  logic                  resetn;
  logic                  start;
  logic [test_width-1:0] in_a;
  logic [test_width-1:0] in_b;
  logic [test_width-1:0] in_m;
  logic [test_width-1:0] result;
  logic                  done;
  logic                  busy;

  int tests_run;
  int tests_failed;
  int fails_before; // assertion count when the current test began

  montgomery_top #(
    .width(test_width)
  ) DUT (
    .clk    (clk),
    .resetn (resetn),
    .start  (start),
    .in_a   (in_a),
    .in_b   (in_b),
    .in_m   (in_m),
    .result (result),
    .done   (done),
    .busy   (busy)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("run timed out after %0d ns with tests still running", watchdog_ns);
    $display("STATUS: FAIL");
    $finish;
  end

  // inputs change 2 ns after the rising edge
  task automatic next_slot();
    @(posedge clk);
    #2;
  endtask

  function automatic logic [test_width-1:0] random_word();
    logic [test_width-1:0] w;
    for (int i = 0; i < test_width / 32; i++) begin
      w[i*32 +: 32] = $urandom;
    end
    return w;
  endfunction

  // odd with the top bit set
  function automatic logic [test_width-1:0] random_modulus();
    logic [test_width-1:0] w;
    w = random_word();
    w[test_width-1] = 1'b1;
    w[0] = 1'b1;
    return w;
  endfunction

  function automatic logic [test_width-1:0] below(input logic [test_width-1:0] m);
    return random_word() % m;
  endfunction

  task automatic finish_test(input string name, input bit no_done);
    int new_fails;
    new_fails = DUT.checks.fail_count - fails_before;
    tests_run++;
    if (no_done) begin
      tests_failed++;
      $display("test %0d (%s) failed: no done pulse within %0d cycles of start",
               tests_run, name, test_width + 8);
    end else if (new_fails != 0) begin
      tests_failed++;
      $display("ERR %0t test %0d (%s): %0d assertion failures",
               $time, tests_run, name, new_fails);
    end else begin
      $display("test %0d (%s): ok", tests_run, name);
    end
  endtask

  // one multiplication with optional ignored starts while busy
  task automatic run_mult(input string name, input logic [test_width-1:0] a,
                          input logic [test_width-1:0] b, input logic [test_width-1:0] m,
                          input bit extra_starts);
    int  k;
    bit  seen;
    fails_before = DUT.checks.fail_count;
    in_a  = a;
    in_b  = b;
    in_m  = m;
    start = 1'b1;
    seen  = 1'b0;
    k     = 0;
    while (!seen && k < test_width + 8) begin
      next_slot();
      k++;
      start = extra_starts && (k % 7 == 3) && (k < test_width + 2); // busy until n+2
      @(negedge clk);
      seen = done;
    end
    repeat (3) begin
      next_slot();
      start = 1'b0;
      in_a = random_word(); // result must not follow the inputs now
      in_b = random_word();
      in_m = random_word();
    end
    finish_test(name, !seen);
  endtask

  initial begin : main
    logic [test_width-1:0] m;
    void'($urandom(seed));
    resetn       = 1'b0;
    start        = 1'b0;
    in_a         = '0;
    in_b         = '0;
    in_m         = '0;
    tests_run    = 0;
    tests_failed = 0;
    fails_before = 0;

    repeat (reset_len) @(posedge clk);
    #2;
    resetn = 1'b1;

    // idle outputs while the inputs wiggle without start
    fails_before = DUT.checks.fail_count;
    repeat (6) begin
      next_slot();
      in_a = random_word();
      in_b = random_word();
      in_m = random_modulus();
    end
    finish_test("idle after reset", 1'b0);

    m = random_modulus();
    run_mult("a zero", '0, below(m), m, 1'b0);
    m = random_modulus();
    run_mult("a and b one", test_width'(1), test_width'(1), m, 1'b0);
    m = random_modulus();
    run_mult("a and b m-1", m - 1'b1, m - 1'b1, m, 1'b0);
    m = random_modulus();
    run_mult("start while busy", below(m), below(m), m, 1'b1);
    for (int i = 0; i < test_count - 5; i++) begin
      m = random_modulus();
      run_mult("random", below(m), below(m), m, 1'b0);
    end

    $display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
             tests_run, tests_run - tests_failed, tests_failed, DUT.checks.fail_count);
    if (tests_failed == 0 && DUT.checks.fail_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
mont_pkg.sv
mont_multiples_if.sv
operand_multiples.sv
mont_digit_core.sv
montgomery_top.sv
tb_montgomery_assertions.sv
tb_montgomery.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the montgomery testbench with verilator

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log=sim.log

verilator --binary --assert -Wno-fatal --top-module tb_montgomery \
  --Mdir "$obj_dir" -o sim_montgomery -f list.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

# keep running past assertion errors so the testbench can report them
"./$obj_dir/sim_montgomery" +verilator+error+limit+100000 > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^STATUS: PASS$" "$log"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see $log"
exit 1
